// ==== arb/arb_row_col.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

module arb_row_col (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`MC_N_BANK_MACHS-1:0] rts_row,
  input  logic [`MC_N_BANK_MACHS-1:0] rts_col,
  input  logic [`MC_N_BANK_MACHS-1:0] rtc,
  input  logic                        insert_maint,
  input  logic                        credit_return,
  arb_grant_if.ctrl                   grant_bus,
  output logic [`MC_N_BANK_MACHS-1:0] sending_row,
  output logic [`MC_N_BANK_MACHS-1:0] sending_col,
  output logic                        rnk_config_strobe,
  output logic                        rnk_config_valid
);
  localparam int NB     = `MC_N_BANK_MACHS;
  localparam int CRED_W = $clog2(`MC_PHY_CREDITS + 1);
  localparam int KILL_W = `MC_RNK2RNK_CLKS - 1;  // Strobe cycle itself is the first

  logic [CRED_W-1:0] credit_cnt;
  logic              have_credit;
  logic              any_sent;
  logic              maint_r;
  logic              row_block;
  logic [NB-1:0]     grant_row;
  logic [NB-1:0]     grant_col;
  logic [NB-1:0]     grant_config;
  logic [NB-1:0]     row_request;
  logic [NB-1:0]     col_request;
  logic [NB-1:0]     cfg_request;
  logic [KILL_W-1:0] rnk_sr;
  logic              rnk_kill;

  assign have_credit = credit_cnt != '0;

  // Without a credit the current grant is fed back so it holds
  assign row_block   = insert_maint | maint_r;
  assign row_request = ((|grant_row && !have_credit) ? grant_row : rts_row)
                       & ~sending_row & {NB{~row_block}};

  assign rnk_kill    = rnk_config_strobe | (|rnk_sr);
  assign col_request = ((|grant_col && !have_credit) ? grant_col : rts_col)
                       & ~sending_col & {NB{~rnk_kill}};

  // Rank switch only when the column side is idle
  assign cfg_request = rtc & {NB{~rnk_kill & ~(|col_request)}};

  round_robin_arb #(.WIDTH(NB)) row_arb (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (row_request),
    .upd_last_master (grant_bus.sent_row),
    .grant_r         (grant_row)
  );

  round_robin_arb #(.WIDTH(NB)) col_arb (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (col_request),
    .upd_last_master (grant_bus.sent_col),
    .grant_r         (grant_col)
  );

  round_robin_arb #(.WIDTH(NB)) cfg_arb (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (cfg_request),
    .upd_last_master (rnk_config_strobe),
    .grant_r         (grant_config)
  );

  assign rnk_config_strobe = |grant_config;

  assign sending_row = grant_row & {NB{have_credit}};
  assign sending_col = grant_col & {NB{have_credit}};

  assign grant_bus.grant_row  = grant_row;
  assign grant_bus.grant_col  = grant_col;
  assign grant_bus.sent_row   = |sending_row;
  assign grant_bus.sent_col   = |sending_col;
  assign grant_bus.sent_maint = maint_r & have_credit;

  assign any_sent = grant_bus.sent_row | grant_bus.sent_col | grant_bus.sent_maint;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt       <= CRED_W'(`MC_PHY_CREDITS);
      maint_r          <= 1'b0;
      rnk_sr           <= '0;
      rnk_config_valid <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - CRED_W'(any_sent) + CRED_W'(credit_return);
      maint_r    <= insert_maint | (maint_r & ~have_credit);  // Waits for a credit
      rnk_sr     <= KILL_W'({rnk_sr, rnk_config_strobe});
      if (rnk_config_strobe) begin
        rnk_config_valid <= 1'b1;
      end
    end
  end

endmodule

// ==== arb/cmd_payload_mux.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

module cmd_payload_mux #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     [`MC_N_BANK_MACHS-1:0] grant,
  input  payload_t [`MC_N_BANK_MACHS-1:0] payloads,
  output payload_t                        sel_payload
);
  localparam int NB = `MC_N_BANK_MACHS;
  localparam int W  = $bits(payload_t);

  logic [W-1:0] acc;

  // Grant is one-hot so the OR of masked payloads is the winner
  always_comb begin
    acc = '0;
    for (int i = 0; i < NB; i++) begin
      acc = acc | (payloads[i] & {W{grant[i]}});
    end
  end

  assign sel_payload = payload_t'(acc);

endmodule

// ==== common/arb_grant_if.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

interface arb_grant_if;

  logic [`MC_N_BANK_MACHS-1:0] grant_row;  // Registered one-hot grants
  logic [`MC_N_BANK_MACHS-1:0] grant_col;
  logic                        sent_row;   // Grant actually issued this cycle
  logic                        sent_col;
  logic                        sent_maint;

  modport ctrl (
    output grant_row, grant_col, sent_row, sent_col, sent_maint
  );

  modport mux (
    input grant_row, grant_col
  );

  modport slot (
    input sent_row, sent_col, sent_maint
  );

endinterface

// ==== common/mc_cmd_pkg.sv ====
`include "mc_consts.svh"

package mc_cmd_pkg;

  // Row command request from a bank machine (activate)
  typedef struct packed {
    logic [`MC_BANK_W-1:0] bank;
    logic [`MC_ROW_W-1:0]  row_addr;
  } row_req_t;

  // Column command request, read unless is_wr is set
  typedef struct packed {
    logic [`MC_BANK_W-1:0] bank;
    logic [`MC_COL_W-1:0]  col_addr;
    logic                  is_wr;
  } col_req_t;

endpackage

// ==== common/mc_consts.svh ====
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// Bank machines feeding the arbiter
`define MC_N_BANK_MACHS 4

// DRAM address fields
`define MC_ROW_W  14
`define MC_COL_W  10
`define MC_BANK_W 3

// Fabric cycles of column blocking after a rank switch
`define MC_RNK2RNK_CLKS 6

// Depth of the PHY command FIFO, one entry per issuing fabric cycle
`define MC_PHY_CREDITS 4

`endif

// ==== common/phy_slot_pkg.sv ====
`include "mc_consts.svh"

package phy_slot_pkg;

  // Address field is sized for the wider of row and column
  localparam int SLOT_ADDR_W = `MC_ROW_W;

  typedef enum logic [2:0] {
    NOP   = 3'd0,
    ACT   = 3'd1,
    RD    = 3'd2,
    WR    = 3'd3,
    MAINT = 3'd4
  } slot_kind_e;

  // One DRAM command slot of a PHY word
  typedef struct packed {
    slot_kind_e            kind;
    logic                  cs_en;
    logic [`MC_BANK_W-1:0] bank;
    logic [SLOT_ADDR_W-1:0] addr;
  } phy_slot_t;

  localparam phy_slot_t SLOT_IDLE = '{
    kind:  NOP,
    cs_en: 1'b0,
    bank:  '0,
    addr:  '0
  };

endpackage

// ==== flist.f ====
+incdir+common
common/mc_cmd_pkg.sv
common/phy_slot_pkg.sv
common/arb_grant_if.sv
src/round_robin_arb.sv
arb/arb_row_col.sv
arb/cmd_payload_mux.sv
src/phy_cmd_slotter.sv
src/mc_arb_top.sv
testbench/tb_clkgen.sv
testbench/tb_mc_arb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_mc_arb \
  -f flist.f \
  -o tb_mc_arb

./obj_dir/tb_mc_arb

// ==== src/mc_arb_top.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

module mc_arb_top #(
  parameter int CWL = 5
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                  [`MC_N_BANK_MACHS-1:0] rts_row,
  input  logic                  [`MC_N_BANK_MACHS-1:0] rts_col,
  input  logic                  [`MC_N_BANK_MACHS-1:0] rtc,
  input  mc_cmd_pkg::row_req_t  [`MC_N_BANK_MACHS-1:0] row_req,
  input  mc_cmd_pkg::col_req_t  [`MC_N_BANK_MACHS-1:0] col_req,
  input  logic                                         insert_maint,
  input  logic                                         credit_return,
  output logic                  [`MC_N_BANK_MACHS-1:0] sending_row,
  output logic                  [`MC_N_BANK_MACHS-1:0] sending_col,
  output logic                                         rnk_config_strobe,
  output logic                                         rnk_config_valid,
  output logic                                         phy_cmd_valid,
  output phy_slot_pkg::phy_slot_t                      phy_slot0,
  output phy_slot_pkg::phy_slot_t                      phy_slot1
);
  mc_cmd_pkg::row_req_t row_cmd;
  mc_cmd_pkg::col_req_t col_cmd;

  arb_grant_if grant_bus ();

  arb_row_col u_arb (
    .clk               (clk),
    .rst_n             (rst_n),
    .rts_row           (rts_row),
    .rts_col           (rts_col),
    .rtc               (rtc),
    .insert_maint      (insert_maint),
    .credit_return     (credit_return),
    .grant_bus         (grant_bus.ctrl),
    .sending_row       (sending_row),
    .sending_col       (sending_col),
    .rnk_config_strobe (rnk_config_strobe),
    .rnk_config_valid  (rnk_config_valid)
  );

  // Payloads follow the registered grants, valid while sent_* is high
  cmd_payload_mux #(.payload_t(mc_cmd_pkg::row_req_t)) u_row_mux (
    .grant       (grant_bus.grant_row),
    .payloads    (row_req),
    .sel_payload (row_cmd)
  );

  cmd_payload_mux #(.payload_t(mc_cmd_pkg::col_req_t)) u_col_mux (
    .grant       (grant_bus.grant_col),
    .payloads    (col_req),
    .sel_payload (col_cmd)
  );

  phy_cmd_slotter #(.CWL(CWL)) u_slotter (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_bus     (grant_bus.slot),
    .row_cmd       (row_cmd),
    .col_cmd       (col_cmd),
    .phy_cmd_valid (phy_cmd_valid),
    .phy_slot0     (phy_slot0),
    .phy_slot1     (phy_slot1)
  );

endmodule

// ==== src/phy_cmd_slotter.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

module phy_cmd_slotter #(
  parameter int CWL = 5
) (
  input  logic                   clk,
  input  logic                   rst_n,
  arb_grant_if.slot              grant_bus,
  input  mc_cmd_pkg::row_req_t   row_cmd,
  input  mc_cmd_pkg::col_req_t   col_cmd,
  output logic                   phy_cmd_valid,
  output phy_slot_pkg::phy_slot_t phy_slot0,
  output phy_slot_pkg::phy_slot_t phy_slot1
);
  // Even CWL puts the column command in slot 0
  localparam bit COL_FIRST = (CWL % 2) == 0;
  localparam int PAD_W     = phy_slot_pkg::SLOT_ADDR_W - `MC_COL_W;

  phy_slot_pkg::phy_slot_t row_word;
  phy_slot_pkg::phy_slot_t col_word;

  always_comb begin
    row_word = phy_slot_pkg::SLOT_IDLE;
    if (grant_bus.sent_maint) begin
      row_word.kind  = phy_slot_pkg::MAINT;
      row_word.cs_en = 1'b1;
    end else if (grant_bus.sent_row) begin
      row_word.kind  = phy_slot_pkg::ACT;
      row_word.cs_en = 1'b1;
      row_word.bank  = row_cmd.bank;
      row_word.addr  = row_cmd.row_addr;
    end
  end

  always_comb begin
    col_word = phy_slot_pkg::SLOT_IDLE;
    if (grant_bus.sent_col) begin
      col_word.kind  = col_cmd.is_wr ? phy_slot_pkg::WR : phy_slot_pkg::RD;
      col_word.cs_en = 1'b1;
      col_word.bank  = col_cmd.bank;
      col_word.addr  = {{PAD_W{1'b0}}, col_cmd.col_addr};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phy_cmd_valid <= 1'b0;
      phy_slot0     <= phy_slot_pkg::SLOT_IDLE;
      phy_slot1     <= phy_slot_pkg::SLOT_IDLE;
    end else begin
      phy_cmd_valid <= grant_bus.sent_row | grant_bus.sent_col | grant_bus.sent_maint;
      phy_slot0     <= COL_FIRST ? col_word : row_word;
      phy_slot1     <= COL_FIRST ? row_word : col_word;
    end
  end

endmodule

// ==== src/round_robin_arb.sv ====
`timescale 1ns/1ps

module round_robin_arb #(
  parameter int WIDTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] req,
  input  logic             upd_last_master,
  output logic [WIDTH-1:0] grant_r
);
  localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  logic [IDX_W-1:0] last_idx;
  logic [WIDTH-1:0] grant_ns;

  function automatic logic [IDX_W-1:0] onehot_to_idx(input logic [WIDTH-1:0] oh);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (oh[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  // Search starts one past the last master and wraps around
  always_comb begin : pick
    int   idx;
    logic found;
    grant_ns = '0;
    found = 1'b0;
    for (int i = 1; i <= WIDTH; i++) begin
      idx = (int'(last_idx) + i) % WIDTH;
      if (!found && req[idx]) begin
        grant_ns[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_r  <= '0;
      last_idx <= IDX_W'(WIDTH - 1);  // Bit 0 wins first
    end else begin
      grant_r <= grant_ns;
      if (upd_last_master) begin
        last_idx <= onehot_to_idx(grant_r);
      end
    end
  end

endmodule

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;  // Released on a falling edge, away from the DUT flops
  end

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== testbench/tb_mc_arb.sv ====
`timescale 1ns/1ps
`include "mc_consts.svh"

module tb_mc_arb;
  localparam int NB = `MC_N_BANK_MACHS;

  localparam int PH_RANDOM = 0;
  localparam int PH_STALL  = 1;
  localparam int PH_FAIR   = 2;
  localparam int PH_RANK   = 3;
  localparam int PH_MAINT  = 4;
  localparam int PH_DRAIN  = 5;

  localparam int LEN_RANDOM = 600;
  localparam int LEN_STALL  = 60;
  localparam int LEN_FAIR   = 300;
  localparam int LEN_RANK   = 200;
  localparam int LEN_MAINT  = 260;
  localparam int LEN_DRAIN  = 40;
  localparam int RUN_CYCLES = LEN_RANDOM + LEN_STALL + LEN_FAIR + LEN_RANK + LEN_MAINT
                              + LEN_DRAIN;
  localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 80;  // Room for reset and drain

  logic                              clk;
  logic                              rst_n;
  logic [NB-1:0]                     rts_row;
  logic [NB-1:0]                     rts_col;
  logic [NB-1:0]                     rtc;
  mc_cmd_pkg::row_req_t [NB-1:0]     row_req;
  mc_cmd_pkg::col_req_t [NB-1:0]     col_req;
  logic                              insert_maint;
  logic                              credit_return;
  logic [NB-1:0]                     sending_row;
  logic [NB-1:0]                     sending_col;
  logic                              rnk_config_strobe;
  logic                              rnk_config_valid;
  logic                              phy_cmd_valid;
  phy_slot_pkg::phy_slot_t           phy_slot0;
  phy_slot_pkg::phy_slot_t           phy_slot1;

  // Reference model state
  int unsigned             lcg_state = 49412;
  int                      phase = PH_RANDOM;
  int                      prev_phase = PH_RANDOM;
  int                      cred = `MC_PHY_CREDITS;
  int                      phy_outstanding = 0;  // Words seen by the PHY minus credits returned
  logic                    maint_pend = 1'b0;
  int                      col_block_left = 0;
  logic                    strobe_seen = 1'b0;
  logic                    resume_armed = 1'b0;
  int                      resume_wait = 0;
  int                      fair_arm = 0;
  int                      hist[$];
  logic                    exp_valid = 1'b0;
  phy_slot_pkg::phy_slot_t exp_slot0 = '0;
  phy_slot_pkg::phy_slot_t exp_slot1 = '0;
  int                      strobes = 0;
  int                      maint_slots = 0;
  int                      stall_cycles = 0;

  tb_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mc_arb_top #(.CWL(5)) DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .rts_row           (rts_row),
    .rts_col           (rts_col),
    .rtc               (rtc),
    .row_req           (row_req),
    .col_req           (col_req),
    .insert_maint      (insert_maint),
    .credit_return     (credit_return),
    .sending_row       (sending_row),
    .sending_col       (sending_col),
    .rnk_config_strobe (rnk_config_strobe),
    .rnk_config_valid  (rnk_config_valid),
    .phy_cmd_valid     (phy_cmd_valid),
    .phy_slot0         (phy_slot0),
    .phy_slot1         (phy_slot1)
  );

  function automatic logic [15:0] lcg_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic bit chance(input int n);
    return (int'(lcg_rand()) % n) == 0;
  endfunction

  function automatic int onehot_idx(input logic [NB-1:0] oh);
    int idx;
    idx = 0;
    for (int i = 0; i < NB; i++) begin
      if (oh[i]) idx = i;
    end
    return idx;
  endfunction

  function automatic phy_slot_pkg::phy_slot_t idle_word();
    phy_slot_pkg::phy_slot_t w;
    w.kind  = phy_slot_pkg::NOP;
    w.cs_en = 1'b0;
    w.bank  = '0;
    w.addr  = '0;
    return w;
  endfunction

  function automatic phy_slot_pkg::phy_slot_t act_word(input mc_cmd_pkg::row_req_t r);
    phy_slot_pkg::phy_slot_t w;
    w       = idle_word();
    w.kind  = phy_slot_pkg::ACT;
    w.cs_en = 1'b1;
    w.bank  = r.bank;
    w.addr  = r.row_addr;
    return w;
  endfunction

  function automatic phy_slot_pkg::phy_slot_t column_word(input mc_cmd_pkg::col_req_t c);
    phy_slot_pkg::phy_slot_t w;
    w       = idle_word();
    w.kind  = c.is_wr ? phy_slot_pkg::WR : phy_slot_pkg::RD;
    w.cs_en = 1'b1;
    w.bank  = c.bank;
    w.addr[`MC_COL_W-1:0] = c.col_addr;  // Upper address bits stay zero
    return w;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s: expected %h actual %h", test, exp, act);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  // Checks the DUT outputs of one fabric cycle and drives the next inputs
  task automatic step_cycle();
    logic                    maint_issue;
    logic                    issued;
    logic                    had_credit;
    int                      idx;
    phy_slot_pkg::phy_slot_t row_w;
    phy_slot_pkg::phy_slot_t col_w;
    if (phase != prev_phase) begin
      hist.delete();
      fair_arm = 4;
      if (prev_phase == PH_STALL) begin
        resume_armed = |rts_row || |rts_col;
        resume_wait  = 0;
      end
      prev_phase = phase;
    end
    if (phy_cmd_valid) phy_outstanding++;
    assert (phy_outstanding <= `MC_PHY_CREDITS)
      else stop_with_error("outstanding PHY commands exceed the FIFO depth");
    assert (phy_cmd_valid == exp_valid)
      else report_mismatch("phy_cmd_valid", 32'(exp_valid), 32'(phy_cmd_valid));
    assert (phy_slot0 == exp_slot0)
      else report_mismatch("phy_slot0", 32'(exp_slot0), 32'(phy_slot0));
    assert (phy_slot1 == exp_slot1)
      else report_mismatch("phy_slot1", 32'(exp_slot1), 32'(phy_slot1));
    if (phy_cmd_valid && phy_slot0.kind == phy_slot_pkg::MAINT) maint_slots++;
    assert ($onehot0(sending_row)) else stop_with_error("more than one row command sent");
    assert ($onehot0(sending_col)) else stop_with_error("more than one column command sent");
    assert ((sending_row & ~rts_row) == '0)
      else stop_with_error("row command sent to a bank machine that is not requesting");
    assert ((sending_col & ~rts_col) == '0)
      else stop_with_error("column command sent to a bank machine that is not requesting");
    assert (!(insert_maint && |sending_row))
      else stop_with_error("row command sent during a maintenance insert");
    maint_issue = maint_pend && cred > 0;
    issued      = |sending_row || |sending_col || maint_issue;
    had_credit  = cred > 0;
    if (!had_credit) begin
      assert (sending_row == '0 && sending_col == '0)
        else stop_with_error("command sent with no PHY credit left");
      if (|rts_row || |rts_col) stall_cycles++;
    end
    assert (!rnk_config_strobe || rtc != '0)
      else stop_with_error("rank-config strobe without a rank-config request");
    if (rnk_config_strobe) begin
      col_block_left = `MC_RNK2RNK_CLKS;
      strobes++;
    end
    if (col_block_left > 0) begin
      assert (sending_col == '0)
        else stop_with_error("column command sent inside the rank-to-rank gap");
      col_block_left--;
    end
    assert (rnk_config_valid == strobe_seen)
      else report_mismatch("rnk_config_valid", 32'(strobe_seen), 32'(rnk_config_valid));
    strobe_seen = strobe_seen | rnk_config_strobe;
    if (phase == PH_FAIR) begin
      if (|sending_row) begin
        idx = onehot_idx(sending_row);
        if (fair_arm == 0) begin
          foreach (hist[i]) begin
            assert (hist[i] != idx)
              else stop_with_error("row grant repeated a bank within four grants");
          end
        end
        hist.push_back(idx);
        if (hist.size() > NB - 1) void'(hist.pop_front());
      end
      if (fair_arm > 0) fair_arm--;
    end
    if (resume_armed) begin
      if (issued) begin
        resume_armed = 1'b0;
      end else begin
        resume_wait++;
        assert (resume_wait <= 4)
          else stop_with_error("issuing did not resume after credits came back");
      end
    end
    // Odd CWL puts the row command into slot 0
    row_w = idle_word();
    if (maint_issue) begin
      row_w.kind  = phy_slot_pkg::MAINT;
      row_w.cs_en = 1'b1;
    end else if (|sending_row) begin
      row_w = act_word(row_req[onehot_idx(sending_row)]);
    end
    col_w = idle_word();
    if (|sending_col) col_w = column_word(col_req[onehot_idx(sending_col)]);
    exp_slot0 = row_w;
    exp_slot1 = col_w;
    exp_valid = issued;
    // PHY side
    if (phase == PH_STALL || `MC_PHY_CREDITS - (cred - int'(issued)) == 0) begin
      credit_return = 1'b0;
    end else if (phase == PH_FAIR || phase == PH_DRAIN) begin
      credit_return = 1'b1;
    end else begin
      credit_return = chance(3);
    end
    insert_maint = phase == PH_MAINT && !insert_maint && chance(12);
    cred       = cred - int'(issued) + int'(credit_return);
    maint_pend = insert_maint | (maint_pend & ~had_credit);
    if (credit_return) phy_outstanding--;
    // Bank machines
    for (int b = 0; b < NB; b++) begin
      if (sending_row[b]) begin
        if (phase != PH_FAIR) rts_row[b] = 1'b0;
      end else if (!rts_row[b] && phase != PH_DRAIN && (phase == PH_FAIR || chance(4))) begin
        rts_row[b]          = 1'b1;
        row_req[b].bank     = 3'(lcg_rand());
        row_req[b].row_addr = 14'(lcg_rand());
      end
      if (sending_col[b]) begin
        rts_col[b] = 1'b0;
      end else if (!rts_col[b] && phase != PH_DRAIN && phase != PH_FAIR
                   && chance(phase == PH_RANK ? 8 : 3)) begin
        rts_col[b]          = 1'b1;
        col_req[b].bank     = 3'(lcg_rand());
        col_req[b].col_addr = 10'(lcg_rand());
        col_req[b].is_wr    = 1'(lcg_rand());
      end
    end
    if (phase != PH_RANK || rnk_config_strobe) begin
      rtc = '0;
    end else if (rtc == '0 && chance(6)) begin
      rtc = NB'(1) << (int'(lcg_rand()) % NB);
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      assert (sending_row == '0 && sending_col == '0 && !rnk_config_strobe
              && !rnk_config_valid && !phy_cmd_valid && !phy_slot0.cs_en
              && !phy_slot1.cs_en)
        else stop_with_error("control output active during reset");
    end else begin
      step_cycle();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_error("watchdog expired before the tests finished");
  end

  initial begin
    rts_row       = '0;
    rts_col       = '0;
    rtc           = '0;
    row_req       = '0;
    col_req       = '0;
    insert_maint  = 1'b0;
    credit_return = 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    phase = PH_RANDOM;
    repeat (LEN_RANDOM) @(posedge clk);
    phase = PH_STALL;
    repeat (LEN_STALL) @(posedge clk);
    phase = PH_FAIR;
    repeat (LEN_FAIR) @(posedge clk);
    phase = PH_RANK;
    repeat (LEN_RANK) @(posedge clk);
    phase = PH_MAINT;
    repeat (LEN_MAINT) @(posedge clk);
    phase = PH_DRAIN;
    repeat (LEN_DRAIN) @(posedge clk);
    assert (strobes > 0) else stop_with_error("no rank-config strobe was seen");
    assert (maint_slots > 0) else stop_with_error("no maintenance slot was seen");
    assert (stall_cycles > 0) else stop_with_error("credits never ran out");
    $display("Testbench passed");
    $finish;
  end

endmodule
